//--- vlog.f
+incdir+verilog
verilog/ringCachePkg.sv
verilog/ringBusIf.sv
verilog/lineStore.sv
verilog/lineAccess.sv
verilog/ringPort.sv
verilog/cacheControl.sv
verilog/ringDataCache.sv
verif/ringMemModel.sv
verif/tbRingDataCache.sv

//--- run.sh
#!/bin/sh
# Build the ring cache testbench with Verilator and run it.

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tbRingDataCache \
	-o tbRingDataCache > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbRingDataCache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1

//--- verif/tbRingDataCache.sv
`timescale 1ns/100ps
`include "ringCache_config.svh"

module tbRingDataCache;

	localparam int numOps = 31;
	localparam int stallLimit = 400;
	localparam ringCachePkg::memOpm ldB = 5'h10;
	localparam ringCachePkg::memOpm ldH = 5'h11;
	localparam ringCachePkg::memOpm ldW = 5'h12;
	localparam ringCachePkg::memOpm ldD = 5'h13;
	localparam ringCachePkg::memOpm ldBu = 5'h14;
	localparam ringCachePkg::memOpm ldHu = 5'h15;
	localparam ringCachePkg::memOpm ldWu = 5'h16;
	localparam ringCachePkg::memOpm stB = 5'h08;
	localparam ringCachePkg::memOpm stH = 5'h09;
	localparam ringCachePkg::memOpm stW = 5'h0A;
	localparam ringCachePkg::memOpm stD = 5'h0B;
	localparam logic [3:0] chkLoad = 4'b0001;
	localparam logic [3:0] expMiss = 4'b0010;
	localparam logic [3:0] useHold = 4'b0100;
	localparam logic [3:0] expWb = 4'b1000; // dirty victim goes out as STX

	logic clock = 1'b0;
	logic rst;
	logic hold;
	logic stall;
	ringCachePkg::addrWord addr;
	ringCachePkg::memOpm opm;
	ringCachePkg::dataWord storeVal;
	ringCachePkg::dataWord loadVal;
	ringCachePkg::ringSeq ringSeqIn;
	ringCachePkg::ringSeq ringSeqOut;
	ringCachePkg::ringOpm ringOpmIn;
	ringCachePkg::ringOpm ringOpmOut;
	ringCachePkg::addrWord ringAddrIn;
	ringCachePkg::addrWord ringAddrOut;
	ringCachePkg::lineData ringDataIn;
	ringCachePkg::lineData ringDataOut;

	ringCachePkg::addrWord opAddr [numOps];
	ringCachePkg::memOpm opCode [numOps];
	ringCachePkg::dataWord opData [numOps];
	logic [3:0] opFlags [numOps];
	ringCachePkg::addrWord opVictim [numOps];
	logic [7:0] mirror [4096];

	ringCachePkg::dataWord lastLoad = '0;
	ringCachePkg::addrWord lastStxAddr = '0;
	ringCachePkg::ringSeq sentSeq = '0;
	ringCachePkg::ringOpm sentOpm = '0;
	ringCachePkg::addrWord sentAddr = '0;
	ringCachePkg::lineData sentData = '0;
	logic sentForeign = 1'b0;
	logic timedOut = 1'b0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int stxCount = 0;
	int forwardCount = 0;

	always #20 clock = ~clock;

	ringDataCache dut_i
	(
		.clock(clock),
		.rst(rst),
		.addr(addr),
		.opm(opm),
		.storeVal(storeVal),
		.hold(hold),
		.loadVal(loadVal),
		.stall(stall),
		.ringSeqIn(ringSeqIn),
		.ringOpmIn(ringOpmIn),
		.ringAddrIn(ringAddrIn),
		.ringDataIn(ringDataIn),
		.ringSeqOut(ringSeqOut),
		.ringOpmOut(ringOpmOut),
		.ringAddrOut(ringAddrOut),
		.ringDataOut(ringDataOut)
	);

	ringMemModel memModel
	(
		.clock(clock),
		.rst(rst),
		.ringSeqOut(ringSeqOut),
		.ringOpmOut(ringOpmOut),
		.ringAddrOut(ringAddrOut),
		.ringDataOut(ringDataOut),
		.ringSeqIn(ringSeqIn),
		.ringOpmIn(ringOpmIn),
		.ringAddrIn(ringAddrIn),
		.ringDataIn(ringDataIn)
	);

	task automatic checkValue(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// foreign slot seen at the DUT input, to be matched on ringOut next cycle
	always @(posedge clock)
	begin
		sentForeign <= !rst && (ringOpmIn != `RBI_OPM_IDLE) && (ringSeqIn[15:8] == 8'h34);
		sentSeq <= ringSeqIn;
		sentOpm <= ringOpmIn;
		sentAddr <= ringAddrIn;
		sentData <= ringDataIn;
	end

	always @(negedge clock)
	begin
		if (sentForeign)
		begin
			checkValue("ringOpmOut", sentOpm, ringOpmOut);
			checkValue("ringSeqOut", sentSeq, ringSeqOut);
			checkValue("ringAddrOut", sentAddr, ringAddrOut);
			checkValue("ringDataOut", sentData, ringDataOut);
			forwardCount++;
		end
		if (!rst && (ringOpmOut == `RBI_OPM_STX))
		begin
			stxCount++;
			lastStxAddr = ringAddrOut;
		end
	end

	task automatic setOp(input int i, input ringCachePkg::addrWord a, input ringCachePkg::memOpm op,
		input ringCachePkg::dataWord val, input logic [3:0] flags, input ringCachePkg::addrWord victim);
		opAddr[i] = a;
		opCode[i] = op;
		opData[i] = val;
		opFlags[i] = flags;
		opVictim[i] = victim;
	endtask

	task automatic loadTable();
		setOp(0, 32'h040, ldD, 64'h0, chkLoad | expMiss, 32'h0); // cold miss
		setOp(1, 32'h048, ldD, 64'h0, chkLoad, 32'h0);
		setOp(2, 32'h041, ldB, 64'h0, chkLoad, 32'h0);
		setOp(3, 32'h043, ldBu, 64'h0, chkLoad, 32'h0);
		setOp(4, 32'h042, ldH, 64'h0, chkLoad, 32'h0);
		setOp(5, 32'h046, ldHu, 64'h0, chkLoad, 32'h0);
		setOp(6, 32'h044, ldW, 64'h0, chkLoad, 32'h0);
		setOp(7, 32'h04C, ldWu, 64'h0, chkLoad, 32'h0);
		setOp(8, 32'h04A, stH, 64'hBEEF, 4'b0000, 32'h0);
		setOp(9, 32'h04A, ldH, 64'h0, chkLoad, 32'h0);
		setOp(10, 32'h04A, ldHu, 64'h0, chkLoad, 32'h0);
		setOp(11, 32'h048, ldD, 64'h0, chkLoad, 32'h0);
		setOp(12, 32'h040, stD, 64'h0123456789ABCDEF, 4'b0000, 32'h0);
		setOp(13, 32'h045, stB, 64'h5A, 4'b0000, 32'h0);
		setOp(14, 32'h041, ldB, 64'h0, chkLoad, 32'h0);
		setOp(15, 32'h041, ldBu, 64'h0, chkLoad, 32'h0);
		setOp(16, 32'h040, ldD, 64'h0, chkLoad, 32'h0);
		setOp(17, 32'h140, ldW, 64'h0, chkLoad | expMiss | expWb, 32'h040);
		setOp(18, 32'h148, ldD, 64'h0, chkLoad, 32'h0);
		setOp(19, 32'h040, ldD, 64'h0, chkLoad | expMiss, 32'h0); // reload after write-back
		setOp(20, 32'h2F0, stW, 64'hCAFEF00D, expMiss, 32'h0);
		setOp(21, 32'h2F0, ldW, 64'h0, chkLoad, 32'h0);
		setOp(22, 32'h2F0, ldWu, 64'h0, chkLoad, 32'h0);
		setOp(23, 32'h3F8, ldH, 64'h0, chkLoad | expMiss | expWb, 32'h2F0);
		setOp(24, 32'h2F0, ldD, 64'h0, chkLoad | expMiss, 32'h0);
		setOp(25, 32'h04C, ldWu, 64'h0, chkLoad | useHold, 32'h0);
		setOp(26, 32'h07E, ldB, 64'h0, chkLoad | expMiss, 32'h0);
		setOp(27, 32'h086, ldHu, 64'h0, chkLoad | expMiss, 32'h0);
		setOp(28, 32'h3F8, stD, 64'hFEDCBA9876543210, expMiss, 32'h0);
		setOp(29, 32'h3FA, ldHu, 64'h0, chkLoad, 32'h0);
		setOp(30, 32'h3FC, ldW, 64'h0, chkLoad, 32'h0);
	endtask

	task automatic copyMirror();
		ringCachePkg::lineData line;
		for (int i = 0; i < 256; i++)
		begin
			line = memModel.mem[i];
			for (int k = 0; k < 16; k++)
				mirror[i*16 + k] = line[8*k +: 8];
		end
	endtask

	// little-endian bytes, extended by size and opm bit 2
	function automatic ringCachePkg::dataWord expectLoad(input ringCachePkg::addrWord a,
		input ringCachePkg::memOpm op);
		ringCachePkg::dataWord v;
		int n;
		n = 1 << op[1:0];
		v = '0;
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = mirror[a[11:0] + i];
		if (!op[2] && (n < 8) && v[8*n - 1])
			for (int i = n; i < 8; i++)
				v[8*i +: 8] = 8'hFF;
		return v;
	endfunction

	task automatic storeMirror(input ringCachePkg::addrWord a, input ringCachePkg::memOpm op,
		input ringCachePkg::dataWord val);
		for (int i = 0; i < (1 << op[1:0]); i++)
			mirror[a[11:0] + i] = val[8*i +: 8];
	endtask

	function automatic ringCachePkg::lineData mirrorLine(input ringCachePkg::addrWord a);
		ringCachePkg::lineData line;
		for (int k = 0; k < 16; k++)
			line[8*k +: 8] = mirror[{a[11:4], 4'h0} + k];
		return line;
	endfunction

	task automatic waitStallLow(output int cycles);
		cycles = 0;
		while (stall && !timedOut)
		begin
			@(negedge clock);
			cycles++;
			if (stall && (cycles >= stallLimit))
				timedOut = 1'b1;
		end
	endtask

	task automatic runOp(input int i);
		ringCachePkg::dataWord expected;
		int cycles;
		int errorsBefore;
		int stxBefore;
		logic missSeen;
		errorsBefore = errorCount;
		stxBefore = stxCount;
		expected = expectLoad(opAddr[i], opCode[i]);
		addr <= opAddr[i];
		opm <= opCode[i];
		storeVal <= opData[i];
		if (opFlags[i][2])
		begin
			hold <= 1'b1;
			repeat (4)
			begin
				@(negedge clock);
				checkValue("loadVal", lastLoad, loadVal);
			end
			hold <= 1'b0;
		end
		@(negedge clock); // op accepted on the edge just passed
		waitStallLow(cycles);
		if (timedOut)
			$display("Test %0d: stall stayed high for %0d cycles", i, cycles);
		else
		begin
			missSeen = (cycles > 0);
			checkValue("stall", opFlags[i][1], missSeen);
			if (missSeen && opFlags[i][0])
				checkValue("loadVal", expected, loadVal);
			opm <= '0;
			@(negedge clock);
			if (!missSeen && opFlags[i][0])
				checkValue("loadVal", expected, loadVal);
			if (opFlags[i][0])
				lastLoad = expected;
			if (opCode[i][3])
				storeMirror(opAddr[i], opCode[i], opData[i]);
			if (opFlags[i][3])
			begin
				checkValue("stxCount", 1, stxCount - stxBefore);
				checkValue("ringAddrOut", opVictim[i], lastStxAddr);
				checkValue("memory line", mirrorLine(opVictim[i]), memModel.mem[opVictim[i][11:4]]);
			end
		end
		if (errorCount == errorsBefore && !timedOut)
			passCount++;
		else
			failCount++;
		$display("Test %0d addr %h opm %h: %s, %0d stall cycles", i, opAddr[i], opCode[i],
			(errorCount == errorsBefore && !timedOut) ? "pass" : "FAIL", cycles);
	endtask

	initial
	begin
		int cycles;
		rst = 1'b1;
		hold = 1'b0;
		addr = '0;
		opm = '0;
		storeVal = '0;
		loadTable();
		repeat (16) @(negedge clock);
		rst <= 1'b0;
		@(negedge clock);
		waitStallLow(cycles); // tag sweep after reset
		copyMirror();
		for (int i = 0; i < numOps && !timedOut; i++)
			runOp(i);
		if (timedOut)
			$display("Run stopped early: the cache never finished a miss");
		$display("Tests passed %0d, failed %0d, mismatches %0d, foreign slots forwarded %0d",
			passCount, failCount, errorCount, forwardCount);
		if (!timedOut && (failCount == 0) && (errorCount == 0))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

//--- verif/ringMemModel.sv
`timescale 1ns/100ps
`include "ringCache_config.svh"

// memory node that closes the ring behind the cache
module ringMemModel
(
	input logic clock,
	input logic rst,
	input ringCachePkg::ringSeq ringSeqOut,
	input ringCachePkg::ringOpm ringOpmOut,
	input ringCachePkg::addrWord ringAddrOut,
	input ringCachePkg::lineData ringDataOut,
	output ringCachePkg::ringSeq ringSeqIn,
	output ringCachePkg::ringOpm ringOpmIn,
	output ringCachePkg::addrWord ringAddrIn,
	output ringCachePkg::lineData ringDataIn
);

	ringCachePkg::lineData mem [256];
	ringCachePkg::ringSeq slotSeq = '0;
	ringCachePkg::ringOpm slotOpm = `RBI_OPM_IDLE;
	ringCachePkg::addrWord slotAddr = '0;
	ringCachePkg::lineData slotData = '0;
	ringCachePkg::lineData respData = '0;
	ringCachePkg::ringSeq respSeq = '0;
	ringCachePkg::ringOpm respOpm = `RBI_OPM_IDLE;
	ringCachePkg::addrWord respAddr = '0;
	logic [31:0] randState = 32'd88;
	logic respPending = 1'b0;
	int respWait = 0;
	int idleCount = 0;

	assign ringSeqIn = slotSeq;
	assign ringOpmIn = slotOpm;
	assign ringAddrIn = slotAddr;
	assign ringDataIn = slotData;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	always @(negedge clock)
	begin
		if (rst)
		begin
			randState = 32'd88;
			for (int i = 0; i < 256; i++)
			begin
				for (int w = 0; w < 4; w++)
				begin
					randState = xorshift(randState);
					mem[i][32*w +: 32] = randState;
				end
			end
			respPending = 1'b0;
			idleCount = 0;
			slotOpm <= `RBI_OPM_IDLE;
			slotSeq <= '0;
		end
		else
		begin
			if (((ringOpmOut == `RBI_OPM_LDX) || (ringOpmOut == `RBI_OPM_STX)) &&
				(ringSeqOut[15:8] == `RING_NODE_ID))
			begin
				if (ringOpmOut == `RBI_OPM_STX)
				begin
					mem[ringAddrOut[11:4]] = ringDataOut;
					respOpm = `RBI_OPM_RESP_ST;
				end
				else
					respOpm = `RBI_OPM_RESP_LD;
				respData = mem[ringAddrOut[11:4]];
				respSeq = ringSeqOut;
				respAddr = ringAddrOut;
				respWait = 3;
				respPending = 1'b1;
			end

			if (respPending && (respWait == 0))
			begin
				slotOpm <= respOpm;
				slotSeq <= respSeq;
				slotAddr <= respAddr;
				slotData <= respData;
				respPending = 1'b0;
			end
			else
			begin
				if (respPending)
					respWait = respWait - 1;
				idleCount = idleCount + 1;
				if (idleCount == 7) // foreign traffic from node 34
				begin
					idleCount = 0;
					randState = xorshift(randState);
					slotOpm <= randState[4] ? `RBI_OPM_RESP_LD : `RBI_OPM_LDX;
					slotSeq <= {8'h34, 4'h0, randState[3:0]};
					slotAddr <= randState;
					slotData <= {4{randState}};
				end
				else
				begin
					slotOpm <= `RBI_OPM_IDLE;
					slotSeq <= '0;
				end
			end
		end
	end

endmodule

//--- verilog/ringDataCache.sv
`timescale 1ns/100ps

module ringDataCache
(
	input logic clock,
	input logic rst,
	input ringCachePkg::addrWord addr,
	input ringCachePkg::memOpm opm,
	input ringCachePkg::dataWord storeVal,
	input logic hold,
	output ringCachePkg::dataWord loadVal,
	output logic stall,
	input ringCachePkg::ringSeq ringSeqIn,
	input ringCachePkg::ringOpm ringOpmIn,
	input ringCachePkg::addrWord ringAddrIn,
	input ringCachePkg::lineData ringDataIn,
	output ringCachePkg::ringSeq ringSeqOut,
	output ringCachePkg::ringOpm ringOpmOut,
	output ringCachePkg::addrWord ringAddrOut,
	output ringCachePkg::lineData ringDataOut
);

	ringCachePkg::lineIndex readIndex;
	ringCachePkg::lineIndex writeIndex;
	ringCachePkg::lineTag writeTag;
	ringCachePkg::lineTag readTag;
	ringCachePkg::lineData writeData;
	ringCachePkg::lineData readData;
	ringCachePkg::lineData accessLine;
	ringCachePkg::lineData mergedLine;
	ringCachePkg::byteOffset accessOffset;
	ringCachePkg::memOpm accessOpm;
	ringCachePkg::dataWord accessStoreVal;
	ringCachePkg::dataWord accessLoadVal;
	logic writeEnable;
	logic writeDirty;
	logic writeValid;
	logic readDirty;
	logic readValid;

	ringBusIf ringBus();

	cacheControl cacheCtl
	(
		.clock(clock),
		.rst(rst),
		.addr(addr),
		.opm(opm),
		.storeVal(storeVal),
		.hold(hold),
		.loadVal(loadVal),
		.stall(stall),
		.readIndex(readIndex),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writeTag(writeTag),
		.writeDirty(writeDirty),
		.writeValid(writeValid),
		.writeData(writeData),
		.readTag(readTag),
		.readDirty(readDirty),
		.readValid(readValid),
		.readData(readData),
		.accessLine(accessLine),
		.accessOffset(accessOffset),
		.accessOpm(accessOpm),
		.accessStoreVal(accessStoreVal),
		.accessLoadVal(accessLoadVal),
		.mergedLine(mergedLine),
		.bus(ringBus.client)
	);

	lineStore lineMem
	(
		.clock(clock),
		.rst(rst),
		.readIndex(readIndex),
		.writeEnable(writeEnable),
		.writeIndex(writeIndex),
		.writeTag(writeTag),
		.writeDirty(writeDirty),
		.writeValid(writeValid),
		.writeData(writeData),
		.readTag(readTag),
		.readDirty(readDirty),
		.readValid(readValid),
		.readData(readData)
	);

	lineAccess lineAcc
	(
		.line(accessLine),
		.offset(accessOffset),
		.opm(accessOpm),
		.storeVal(accessStoreVal),
		.loadVal(accessLoadVal),
		.mergedLine(mergedLine)
	);

	ringPort ringNode
	(
		.clock(clock),
		.rst(rst),
		.ringSeqIn(ringSeqIn),
		.ringOpmIn(ringOpmIn),
		.ringAddrIn(ringAddrIn),
		.ringDataIn(ringDataIn),
		.ringSeqOut(ringSeqOut),
		.ringOpmOut(ringOpmOut),
		.ringAddrOut(ringAddrOut),
		.ringDataOut(ringDataOut),
		.bus(ringBus.node)
	);

endmodule

//--- verilog/cacheControl.sv
`timescale 1ns/100ps
`include "ringCache_config.svh"

module cacheControl
(
	input logic clock,
	input logic rst,
	input ringCachePkg::addrWord addr,
	input ringCachePkg::memOpm opm,
	input ringCachePkg::dataWord storeVal,
	input logic hold,
	output ringCachePkg::dataWord loadVal,
	output logic stall,
	output ringCachePkg::lineIndex readIndex,
	output logic writeEnable,
	output ringCachePkg::lineIndex writeIndex,
	output ringCachePkg::lineTag writeTag,
	output logic writeDirty,
	output logic writeValid,
	output ringCachePkg::lineData writeData,
	input ringCachePkg::lineTag readTag,
	input logic readDirty,
	input logic readValid,
	input ringCachePkg::lineData readData,
	output ringCachePkg::lineData accessLine,
	output ringCachePkg::byteOffset accessOffset,
	output ringCachePkg::memOpm accessOpm,
	output ringCachePkg::dataWord accessStoreVal,
	input ringCachePkg::dataWord accessLoadVal,
	input ringCachePkg::lineData mergedLine,
	ringBusIf.client bus
);

	ringCachePkg::controlState state;
	ringCachePkg::addrWord stageAddr;
	ringCachePkg::memOpm stageOpm;
	ringCachePkg::dataWord stageStoreVal;
	ringCachePkg::lineIndex stageIndex;
	ringCachePkg::lineTag stageTag;
	ringCachePkg::lineIndex sweepCount;
	ringCachePkg::lineData fillLine;
	logic [`RING_ROVER_BITS-1:0] rover;
	logic sweeping;
	logic stageActive;
	logic hit;
	logic lineReady;
	logic filling;
	logic missStart;
	logic respMatch;

	assign stageIndex = stageAddr[`LINE_OFFSET_BITS +: `CACHE_INDEX_BITS];
	assign stageTag = stageAddr[`ADDR_BITS-1 -: `LINE_TAG_BITS];
	assign stageActive = stageOpm[4] || stageOpm[3];
	assign hit = readValid && (readTag == stageTag);
	assign lineReady = (state == ringCachePkg::idle) && hit;
	assign filling = (state == ringCachePkg::fillWrite);
	assign missStart = (state == ringCachePkg::idle) && stageActive && !hit && !sweeping;
	assign respMatch = bus.respValid && (bus.respSeq == bus.reqSeq);

	assign stall = sweeping || (state != ringCachePkg::idle) || (stageActive && !hit);
	// a stalled or held op keeps its line on the read port
	assign readIndex = (stall || hold) ? stageIndex : addr[`LINE_OFFSET_BITS +: `CACHE_INDEX_BITS];

	assign writeEnable = filling || (lineReady && stageOpm[3]);
	assign writeIndex = stageIndex;
	assign writeTag = stageTag;
	assign writeValid = 1'b1;
	assign writeDirty = !filling; // store hit
	assign writeData = filling ? fillLine : mergedLine;

	assign accessLine = filling ? fillLine : readData;
	assign accessOffset = stageAddr[`LINE_OFFSET_BITS-1:0];
	assign accessOpm = stageOpm;
	assign accessStoreVal = stageStoreVal;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			sweeping <= 1'b1; // matches the tag clear in lineStore
			sweepCount <= '0;
		end
		else if (sweeping)
		begin
			sweepCount <= sweepCount + 1'b1;
			if (sweepCount == '1)
				sweeping <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			stageOpm <= '0;
		else if (!stall && !hold)
			stageOpm <= opm;
	end

	always_ff @(posedge clock)
	begin
		if (!stall && !hold)
		begin
			stageAddr <= addr;
			stageStoreVal <= storeVal;
		end
		if (!hold && stageOpm[4] && (lineReady || filling))
			loadVal <= accessLoadVal;
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= ringCachePkg::idle;
			bus.reqPending <= 1'b0;
			rover <= '0;
		end
		else
		begin
			case (state)
				ringCachePkg::idle:
					if (missStart)
					begin
						bus.reqPending <= 1'b1;
						if (readValid && readDirty)
							state <= ringCachePkg::writeBackSend;
						else
							state <= ringCachePkg::refillSend;
					end
				ringCachePkg::writeBackSend:
					if (bus.reqSent)
					begin
						bus.reqPending <= 1'b0;
						rover <= rover + 1'b1;
						state <= ringCachePkg::writeBackWait;
					end
				ringCachePkg::writeBackWait:
					if (respMatch)
					begin
						bus.reqPending <= 1'b1;
						state <= ringCachePkg::refillSend;
					end
				ringCachePkg::refillSend:
					if (bus.reqSent)
					begin
						bus.reqPending <= 1'b0;
						rover <= rover + 1'b1;
						state <= ringCachePkg::refillWait;
					end
				ringCachePkg::refillWait:
					if (respMatch)
						state <= ringCachePkg::fillWrite;
				default:
					state <= ringCachePkg::idle; // fill lands, retry follows
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (missStart)
		begin
			bus.reqSeq <= {`RING_NODE_ID, {(8 - `RING_ROVER_BITS){1'b0}}, rover};
			bus.reqData <= readData;
			if (readValid && readDirty)
			begin
				bus.reqOpm <= `RBI_OPM_STX;
				bus.reqAddr <= {readTag, stageIndex, {`LINE_OFFSET_BITS{1'b0}}};
			end
			else
			begin
				bus.reqOpm <= `RBI_OPM_LDX;
				bus.reqAddr <= {stageTag, stageIndex, {`LINE_OFFSET_BITS{1'b0}}};
			end
		end
		else if ((state == ringCachePkg::writeBackWait) && respMatch)
		begin
			bus.reqSeq <= {`RING_NODE_ID, {(8 - `RING_ROVER_BITS){1'b0}}, rover};
			bus.reqOpm <= `RBI_OPM_LDX;
			bus.reqAddr <= {stageTag, stageIndex, {`LINE_OFFSET_BITS{1'b0}}};
		end

		if ((state == ringCachePkg::refillWait) && respMatch)
			fillLine <= bus.respData;
	end

endmodule

//--- verilog/ringPort.sv
`timescale 1ns/100ps
`include "ringCache_config.svh"

module ringPort
(
	input logic clock,
	input logic rst,
	input ringCachePkg::ringSeq ringSeqIn,
	input ringCachePkg::ringOpm ringOpmIn,
	input ringCachePkg::addrWord ringAddrIn,
	input ringCachePkg::lineData ringDataIn,
	output ringCachePkg::ringSeq ringSeqOut,
	output ringCachePkg::ringOpm ringOpmOut,
	output ringCachePkg::addrWord ringAddrOut,
	output ringCachePkg::lineData ringDataOut,
	ringBusIf.node bus
);

	logic slotIdle;
	logic respMine;
	logic slotFree;
	logic insertReq;

	assign slotIdle = (ringOpmIn == `RBI_OPM_IDLE);
	assign respMine = (ringOpmIn[7:6] == 2'b01) && (ringSeqIn[15:8] == `RING_NODE_ID);
	assign slotFree = slotIdle || respMine; // own responses are consumed
	assign insertReq = slotFree && bus.reqPending && !bus.reqSent;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ringOpmOut <= `RBI_OPM_IDLE;
			ringSeqOut <= '0;
			bus.reqSent <= 1'b0;
			bus.respValid <= 1'b0;
		end
		else
		begin
			bus.reqSent <= insertReq;
			bus.respValid <= respMine;
			if (insertReq)
			begin
				ringOpmOut <= bus.reqOpm;
				ringSeqOut <= bus.reqSeq;
			end
			else if (slotFree)
			begin
				ringOpmOut <= `RBI_OPM_IDLE;
				ringSeqOut <= '0;
			end
			else
			begin
				ringOpmOut <= ringOpmIn; // foreign slot passes through
				ringSeqOut <= ringSeqIn;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (insertReq)
		begin
			ringAddrOut <= bus.reqAddr;
			ringDataOut <= bus.reqData;
		end
		else
		begin
			ringAddrOut <= ringAddrIn;
			ringDataOut <= ringDataIn;
		end
		bus.respData <= ringDataIn;
		bus.respSeq <= ringSeqIn;
	end

endmodule

//--- verilog/lineAccess.sv
`timescale 1ns/100ps

module lineAccess
(
	input ringCachePkg::lineData line,
	input ringCachePkg::byteOffset offset,
	input ringCachePkg::memOpm opm,
	input ringCachePkg::dataWord storeVal,
	output ringCachePkg::dataWord loadVal,
	output ringCachePkg::lineData mergedLine
);

	logic [63:0] ex1;
	logic [31:0] ex2;
	logic [15:0] ex3;
	logic [7:0] ex4;
	logic signBit;
	logic [15:0] ins3;
	logic [31:0] ins2;
	logic [63:0] ins1;

	// accesses are naturally aligned, so each stage halves the window
	always_comb
	begin
		ex1 = offset[3] ? line[127:64] : line[63:0];
		ex2 = offset[2] ? ex1[63:32] : ex1[31:0];
		ex3 = offset[1] ? ex2[31:16] : ex2[15:0];
		ex4 = offset[0] ? ex3[15:8] : ex3[7:0];

		case (opm[1:0])
			2'b00: signBit = ex4[7];
			2'b01: signBit = ex3[15];
			2'b10: signBit = ex2[31];
			default: signBit = 1'b0;
		endcase
		signBit = signBit && !opm[2]; // zext clears it

		case (opm[1:0])
			2'b00: loadVal = {{56{signBit}}, ex4};
			2'b01: loadVal = {{48{signBit}}, ex3};
			2'b10: loadVal = {{32{signBit}}, ex2};
			default: loadVal = ex1;
		endcase

		if (opm[1:0] == 2'b00)
		begin
			if (offset[0])
				ins3 = {storeVal[7:0], ex3[7:0]};
			else
				ins3 = {ex3[15:8], storeVal[7:0]};
		end
		else
			ins3 = storeVal[15:0];

		if (opm[1])
			ins2 = storeVal[31:0];
		else if (offset[1])
			ins2 = {ins3, ex2[15:0]};
		else
			ins2 = {ex2[31:16], ins3};

		if (opm[1:0] == 2'b11)
			ins1 = storeVal;
		else if (offset[2])
			ins1 = {ins2, ex1[31:0]};
		else
			ins1 = {ex1[63:32], ins2};

		mergedLine = offset[3] ? {ins1, line[63:0]} : {line[127:64], ins1};
	end

endmodule

//--- verilog/lineStore.sv
`timescale 1ns/100ps
`include "ringCache_config.svh"

module lineStore
(
	input logic clock,
	input logic rst,
	input ringCachePkg::lineIndex readIndex,
	input logic writeEnable,
	input ringCachePkg::lineIndex writeIndex,
	input ringCachePkg::lineTag writeTag,
	input logic writeDirty,
	input logic writeValid,
	input ringCachePkg::lineData writeData,
	output ringCachePkg::lineTag readTag,
	output logic readDirty,
	output logic readValid,
	output ringCachePkg::lineData readData
);

	ringCachePkg::lineTag tagArray [`CACHE_LINES];
	logic validArray [`CACHE_LINES];
	logic dirtyArray [`CACHE_LINES];
	ringCachePkg::lineData dataArray [`CACHE_LINES];

	ringCachePkg::lineIndex sweepIndex;
	logic sweeping;
	logic writeNow;
	logic bypass;

	assign writeNow = writeEnable && !sweeping;
	assign bypass = writeNow && (writeIndex == readIndex); // write-first on same index

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			sweeping <= 1'b1;
			sweepIndex <= '0;
		end
		else if (sweeping)
		begin
			sweepIndex <= sweepIndex + 1'b1;
			if (sweepIndex == '1)
				sweeping <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (sweeping)
		begin
			validArray[sweepIndex] <= 1'b0;
			dirtyArray[sweepIndex] <= 1'b0;
			tagArray[sweepIndex] <= '0;
		end
		else if (writeNow)
		begin
			validArray[writeIndex] <= writeValid;
			dirtyArray[writeIndex] <= writeDirty;
			tagArray[writeIndex] <= writeTag;
			dataArray[writeIndex] <= writeData;
		end

		if (bypass)
		begin
			readTag <= writeTag;
			readValid <= writeValid;
			readDirty <= writeDirty;
			readData <= writeData;
		end
		else
		begin
			readTag <= tagArray[readIndex];
			readValid <= validArray[readIndex];
			readDirty <= dirtyArray[readIndex];
			readData <= dataArray[readIndex];
		end
	end

endmodule

//--- verilog/ringBusIf.sv
`timescale 1ns/100ps

interface ringBusIf;

	ringCachePkg::ringSeq reqSeq;
	ringCachePkg::ringOpm reqOpm;
	ringCachePkg::addrWord reqAddr;
	ringCachePkg::lineData reqData;
	logic reqPending;
	logic reqSent; // one-cycle pulse once the slot is taken
	logic respValid;
	ringCachePkg::lineData respData;
	ringCachePkg::ringSeq respSeq;

	modport node
	(
		input reqSeq, reqOpm, reqAddr, reqData, reqPending,
		output reqSent, respValid, respData, respSeq
	);

	modport client
	(
		output reqSeq, reqOpm, reqAddr, reqData, reqPending,
		input reqSent, respValid, respData, respSeq
	);

endinterface

//--- verilog/ringCachePkg.sv
`include "ringCache_config.svh"

package ringCachePkg;

	typedef logic [`ADDR_BITS-1:0] addrWord;
	typedef logic [`DATA_BITS-1:0] dataWord;
	typedef logic [`LINE_BITS-1:0] lineData;
	typedef logic [`CACHE_INDEX_BITS-1:0] lineIndex;
	typedef logic [`LINE_TAG_BITS-1:0] lineTag;
	typedef logic [`LINE_OFFSET_BITS-1:0] byteOffset;

	// {load, store, zext, size[1:0]}
	typedef logic [4:0] memOpm;

	// {nodeId[7:0], 4'h0, rover[3:0]}
	typedef logic [15:0] ringSeq;
	typedef logic [15:0] ringOpm;

	typedef enum logic [2:0]
	{
		idle,
		writeBackSend,
		writeBackWait,
		refillSend,
		refillWait,
		fillWrite
	} controlState;

endpackage

//--- verilog/ringCache_config.svh
`ifndef RING_CACHE_CONFIG_SVH
`define RING_CACHE_CONFIG_SVH

`define ADDR_BITS          32
`define DATA_BITS          64
`define CACHE_INDEX_BITS   4
`define CACHE_LINES        (1 << `CACHE_INDEX_BITS)
`define LINE_BYTES         16
`define LINE_OFFSET_BITS   4
`define LINE_BITS          (`LINE_BYTES * 8)
`define LINE_TAG_BITS      (`ADDR_BITS - `CACHE_INDEX_BITS - `LINE_OFFSET_BITS)

`define RING_NODE_ID       8'h12
`define RING_ROVER_BITS    4

// responses carry 2'b01 in opm[7:6]
`define RBI_OPM_IDLE       16'h0000
`define RBI_OPM_LDX        16'h0084
`define RBI_OPM_STX        16'h00A4
`define RBI_OPM_RESP_LD    16'h0070
`define RBI_OPM_RESP_ST    16'h0060

`endif
